// ==== hist_vectors.txt ====
# C = clear all bins | S v0 bin0 v1 bin1 = one sample cycle, hex fields
# R bin count = read bin (hex), expected sum of both lanes (decimal)
C
S 1 03 0 00
S 0 00 1 07
R 03 1
R 07 1
R 00 0
S 1 0a 1 0a
S 1 0a 1 0a
S 1 0a 0 00
R 0a 5
S 1 11 1 11
R 11 2
S 0 11 1 11
S 1 11 0 00
R 11 4
R 11 4
R 3f 0
C
S 1 3f 1 3f
S 1 3f 1 3f
R 3f 4

// ==== sim.f ====
+incdir+.
hist_pkg.sv
dp_sram.sv
hist_bank.sv
bin_merge.sv
hist_top.sv
tb_hist.sv

// ==== Makefile ====
# Verilator flow for the histogram engine, run from the project root
VERILATOR ?= verilator
TOP       ?= tb_hist
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST PASSED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# fails unless the pass message shows up in the output
sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_hist.sv ====
/*
 * Testbench for the two-lane histogram engine.
 * Replays hist_vectors.txt (clear, sample and read commands), then drives
 * a seeded random burst against a per-lane count model and reads every bin.
 * Run it from the project root so that the vector file is found.
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module tb_hist;

	localparam int NUM_BINS   = `HIST_NUM_BINS;
	localparam int COUNT_MASK = (1 << `HIST_COUNT_BITS) - 1;  // one bank wraps here
	localparam int WAIT_LIMIT = 200;                          // cycles before a wait gives up

	logic                   clk_a;
	logic                   reset;
	logic                   clear;
	hist_pkg::lane_t        lane0;
	hist_pkg::lane_t        lane1;
	logic                   rd_en;
	hist_pkg::bin_t         rd_bin;
	logic                   busy;
	hist_pkg::read_result_t result;

	int          errors;
	int          checks;
	int          model0 [NUM_BINS];  // lane 0 counts, random phase
	int          model1 [NUM_BINS];
	logic [31:0] rng;
	bit          timed_out;          // a wait gave up, skip the rest

	hist_top dut0 (
		.clk_a  (clk_a),
		.reset  (reset),
		.clear  (clear),
		.lane0  (lane0),
		.lane1  (lane1),
		.rd_en  (rd_en),
		.rd_bin (rd_bin),
		.busy   (busy),
		.result (result)
	);

	always #10 clk_a = ~clk_a;  // 20 ns period

	function automatic hist_pkg::lane_t make_lane(input logic v, input hist_pkg::bin_t b);
		hist_pkg::lane_t l;
		l.valid = v;
		l.bin   = b;
		return l;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic end_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	// lanes strobe the neighbouring bins together with rd_en, the bank must drop them
	task automatic read_bin(input hist_pkg::bin_t bin, input int expected, input string name);
		int lat;
		@(posedge clk_a);
		rd_en  <= 1'b1;
		rd_bin <= bin;
		lane0  <= make_lane(1'b1, hist_pkg::bin_t'(bin + 1));
		lane1  <= make_lane(1'b1, hist_pkg::bin_t'(bin + 2));
		@(posedge clk_a);  // dut samples rd_en here
		rd_en <= 1'b0;
		lane0 <= '0;
		lane1 <= '0;
		lat = 0;
		do begin
			@(negedge clk_a);
			lat++;
		end while (!result.valid && lat < 10);
		if (!result.valid) begin
			errors++;
			timed_out = 1'b1;
			$display("no valid result came back for %s", name);
		end else begin
			checks += 2;
			if (lat != 2) begin
				errors++;
				$display("Error %s latency: expected 2, actual %0d", name, lat);
			end
			if (int'(result.total) != expected) begin
				errors++;
				$display("Error %s: expected %0d, actual %0d", name, expected, result.total);
			end
		end
	endtask

	// clear pulse, samples strobed during the sweep, then an all-zero readout
	task automatic clear_bins(input string name);
		int high;
		int b;
		@(posedge clk_a);
		clear <= 1'b1;
		lane0 <= make_lane(1'b1, 6'd1);  // same cycle as clear, dropped
		lane1 <= make_lane(1'b1, 6'd2);
		@(posedge clk_a);
		clear <= 1'b0;
		high = 0;
		@(negedge clk_a);
		while (busy && high < WAIT_LIMIT) begin
			high++;
			@(posedge clk_a);
			lane0 <= make_lane(high < NUM_BINS, hist_pkg::bin_t'(high));  // through last busy cycle
			lane1 <= make_lane(high < NUM_BINS, hist_pkg::bin_t'(high + 7));
			@(negedge clk_a);
		end
		if (busy) begin
			errors++;
			timed_out = 1'b1;
			$display("busy never fell after the clear in %s", name);
		end else begin
			checks++;
			if (high != NUM_BINS) begin
				errors++;
				$display("Error %s busy cycles: expected %0d, actual %0d", name, NUM_BINS, high);
			end
			for (b = 0; b < NUM_BINS && !timed_out; b++) begin
				model0[b] = 0;
				model1[b] = 0;
				read_bin(hist_pkg::bin_t'(b), 0, $sformatf("%s bin %0d", name, b));
			end
		end
	endtask

	task automatic run_vectors(input int fd);
		string line;
		byte   cmd;
		int    line_no;
		int    n;
		int    v0;
		int    b0;
		int    v1;
		int    b1;
		int    expected;
		line_no = 0;
		while (!$feof(fd) && !timed_out) begin
			line = "";
			n = $fgets(line, fd);
			line_no++;
			cmd = (line.len() > 0) ? line[0] : 8'd0;
			case (cmd)
				"C": clear_bins($sformatf("line %0d clear", line_no));
				"S": begin
					n = $sscanf(line, "S %h %h %h %h", v0, b0, v1, b1);
					if (n != 4) begin
						errors++;
						$display("line %0d of the vector file is malformed", line_no);
					end
					@(posedge clk_a);  // held until the next command drives
					lane0 <= make_lane(v0[0], hist_pkg::bin_t'(b0));
					lane1 <= make_lane(v1[0], hist_pkg::bin_t'(b1));
				end
				"R": begin
					n = $sscanf(line, "R %h %d", b0, expected);
					if (n != 2) begin
						errors++;
						$display("line %0d of the vector file is malformed", line_no);
					end
					read_bin(hist_pkg::bin_t'(b0), expected,
						$sformatf("line %0d read bin %0d", line_no, b0));
				end
				default: ;  // comment or blank line
			endcase
		end
	endtask

	task automatic run_random();
		hist_pkg::bin_t bin_a;
		hist_pkg::bin_t bin_b;
		int             i;
		int             b;
		clear_bins("random clear");
		for (i = 0; i < 300; i++) begin
			rng   = xorshift32(rng);
			bin_a = hist_pkg::bin_t'(rng[3:0]);  // narrow range, lots of repeat hits
			bin_b = hist_pkg::bin_t'(rng[13:8]);
			@(posedge clk_a);
			lane0 <= make_lane(rng[16], bin_a);
			lane1 <= make_lane(rng[17], bin_b);
			if (rng[16])
				model0[bin_a]++;
			if (rng[17])
				model1[bin_b]++;
		end
		@(posedge clk_a);
		lane0 <= '0;
		lane1 <= '0;
		for (b = 0; b < NUM_BINS && !timed_out; b++)
			read_bin(hist_pkg::bin_t'(b), (model0[b] & COUNT_MASK) + (model1[b] & COUNT_MASK),
				$sformatf("random bin %0d", b));
	endtask

	initial begin
		int fd;
		clk_a     = 1'b0;
		reset     = 1'b1;
		clear     = 1'b0;
		lane0     = '0;
		lane1     = '0;
		rd_en     = 1'b0;
		rd_bin    = '0;
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		rng       = 32'd4;  // xorshift seed
		repeat (10) @(posedge clk_a);
		reset <= 1'b0;
		fd = $fopen("hist_vectors.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open hist_vectors.txt");
		end else begin
			run_vectors(fd);
			$fclose(fd);
			if (!timed_out)
				run_random();
		end
		end_run();
	end

endmodule

// ==== hist_top.sv ====
/*
 * Top level of the two-lane histogram engine.
 * lane0 feeds bank 0 and lane1 feeds bank 1. Both banks share clear,
 * rd_en and rd_bin. The merge stage returns the summed count on result
 * two cycles after rd_en. busy is high while either bank is clearing.
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_top (
	input  logic                    clk_a,
	input  logic                    reset,
	input  logic                    clear,
	input  hist_pkg::lane_t         lane0,
	input  hist_pkg::lane_t         lane1,
	input  logic                    rd_en,
	input  hist_pkg::bin_t          rd_bin,
	output logic                    busy,
	output hist_pkg::read_result_t  result
);

	hist_pkg::bank_result_t bank0_result;
	hist_pkg::bank_result_t bank1_result;
	logic busy0;
	logic busy1;

	hist_bank u_bank0 (
		.clk_a       (clk_a),
		.reset       (reset),
		.clear       (clear),
		.lane        (lane0),
		.rd_en       (rd_en),
		.rd_bin      (rd_bin),
		.busy        (busy0),
		.bank_result (bank0_result)
	);

	hist_bank u_bank1 (
		.clk_a       (clk_a),
		.reset       (reset),
		.clear       (clear),
		.lane        (lane1),
		.rd_en       (rd_en),
		.rd_bin      (rd_bin),
		.busy        (busy1),
		.bank_result (bank1_result)
	);

	bin_merge u_merge (
		.clk_a  (clk_a),
		.reset  (reset),
		.bank0  (bank0_result),
		.bank1  (bank1_result),
		.busy0  (busy0),
		.busy1  (busy1),
		.busy   (busy),
		.result (result)
	);

endmodule

// ==== bin_merge.sv ====
/*
 * Merge stage for the two histogram banks.
 * Registers the sum of both bank counts, so result is valid one cycle
 * after the banks answer, two cycles after rd_en.
 * busy is the OR of both bank busy levels.
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module bin_merge (
	input  logic                    clk_a,
	input  logic                    reset,
	input  hist_pkg::bank_result_t  bank0,
	input  hist_pkg::bank_result_t  bank1,
	input  logic                    busy0,
	input  logic                    busy1,
	output logic                    busy,
	output hist_pkg::read_result_t  result
);

	logic             res_valid;
	hist_pkg::total_t res_total;  // payload, held between reads

	always_ff @(posedge clk_a) begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= bank0.valid && bank1.valid;  // both banks answered
	end

	always_ff @(posedge clk_a) begin
		if (bank0.valid)
			res_total <= hist_pkg::total_t'(bank0.count) + hist_pkg::total_t'(bank1.count);
	end

	assign result = '{valid: res_valid, total: res_total};
	assign busy   = busy0 | busy1;

	// banks see the same rd_en and clear, so they answer together
	a_valid_agree: assert property (
		@(posedge clk_a) disable iff (reset) bank0.valid == bank1.valid
	) else $error("bin_merge bank valid bits disagree");

endmodule

// ==== hist_bank.sv ====
/*
 * One lane's histogram bank.
 * A clear pulse starts a sweep that writes zero to every bin. busy is high for the whole sweep.
 * When idle, a lane sample reads its bin, adds one and writes it back on the next cycle.
 * A bypass register feeds the last write-back to the next access of the same bin.
 * A host read takes the read port and answers on bank_result one cycle later.
 * Samples during busy, on the clear cycle or with rd_en high are dropped.
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_bank (
	input  logic                    clk_a,
	input  logic                    reset,
	input  logic                    clear,
	input  hist_pkg::lane_t         lane,
	input  logic                    rd_en,
	input  hist_pkg::bin_t          rd_bin,
	output logic                    busy,
	output hist_pkg::bank_result_t  bank_result
);

	hist_pkg::bank_state_t state;
	hist_pkg::bin_t        sweep_addr;  // next bin to zero

	logic host_go;    // host read accepted
	logic sample_go;  // lane sample accepted

	logic           s1_valid;  // access in flight, read data due now
	logic           s1_host;   // in-flight access is a host read
	hist_pkg::bin_t s1_bin;

	logic             wb_valid;  // write-back done last cycle
	hist_pkg::bin_t   wb_bin;
	hist_pkg::count_t wb_data;

	logic             wb_en;
	hist_pkg::count_t base;       // current count of s1_bin
	hist_pkg::count_t inc_value;

	logic             ram_wr_en;
	hist_pkg::bin_t   ram_wr_addr;
	hist_pkg::count_t ram_wr_data;
	logic             ram_rd_en;
	hist_pkg::bin_t   ram_rd_addr;
	hist_pkg::count_t ram_rd_data;

	assign busy      = (state == hist_pkg::BANK_CLEAR);
	assign host_go   = rd_en && !busy;
	assign sample_go = lane.valid && !rd_en && !clear && !busy;  // host read wins the port

	// clear sweep FSM
	always_ff @(posedge clk_a) begin
		if (reset) begin
			state      <= hist_pkg::BANK_IDLE;
			sweep_addr <= '0;
		end else begin
			case (state)
				hist_pkg::BANK_IDLE: begin
					if (clear) begin
						state      <= hist_pkg::BANK_CLEAR;
						sweep_addr <= '0;
					end
				end
				hist_pkg::BANK_CLEAR: begin
					sweep_addr <= sweep_addr + 1'b1;
					if (sweep_addr == hist_pkg::bin_t'(`HIST_NUM_BINS - 1))
						state <= hist_pkg::BANK_IDLE;  // last bin zeroed
				end
				default: state <= hist_pkg::BANK_IDLE;
			endcase
		end
	end

	assign ram_rd_en   = host_go || sample_go;
	assign ram_rd_addr = rd_en ? rd_bin : lane.bin;

	// pipeline control
	always_ff @(posedge clk_a) begin
		if (reset) begin
			s1_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			s1_valid <= ram_rd_en;
			wb_valid <= wb_en;
		end
	end

	// pipeline payload
	always_ff @(posedge clk_a) begin
		s1_bin  <= ram_rd_addr;
		s1_host <= rd_en;
		wb_bin  <= s1_bin;   // remember last write for forwarding
		wb_data <= inc_value;
	end

	// RAM read raced last cycle's write, so take the bypass on a match
	assign base      = (wb_valid && wb_bin == s1_bin) ? wb_data : ram_rd_data;
	assign inc_value = base + 1'b1;  // wraps at the top
	assign wb_en     = s1_valid && !s1_host;

	// write port owned by the sweep while clearing
	always_comb begin
		if (busy) begin
			ram_wr_en   = 1'b1;
			ram_wr_addr = sweep_addr;
			ram_wr_data = '0;
		end else begin
			ram_wr_en   = wb_en;
			ram_wr_addr = s1_bin;
			ram_wr_data = inc_value;
		end
	end

	assign bank_result = '{valid: s1_valid && s1_host, count: base};

	dp_sram u_sram (
		.clk_a   (clk_a),
		.wr_en   (ram_wr_en),
		.wr_addr (ram_wr_addr),
		.wr_data (ram_wr_data),
		.rd_en   (ram_rd_en),
		.rd_addr (ram_rd_addr),
		.rd_data (ram_rd_data)
	);

	// a strobe on a clear or busy cycle never becomes a write-back
	a_no_count_busy: assert property (
		@(posedge clk_a) disable iff (reset)
		((busy || clear) && lane.valid) |=> !wb_en
	) else $error("hist_bank counted a sample during clear");

	a_no_wb_in_sweep: assert property (
		@(posedge clk_a) disable iff (reset) busy |-> !wb_en
	) else $error("hist_bank write-back collided with sweep write");

endmodule

// ==== dp_sram.sv ====
/*
 * Generic inferred dual-port SRAM with one write port and one read port.
 * The write lands at the clock edge where wr_en is presented.
 * Read data appears on rd_data one cycle after rd_en and holds until the next read.
 * A read of the address being written in the same cycle returns the old word.
 * Depth and width come from the size header.
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module dp_sram (
	input  logic              clk_a,
	input  logic              wr_en,
	input  hist_pkg::bin_t    wr_addr,
	input  hist_pkg::count_t  wr_data,
	input  logic              rd_en,
	input  hist_pkg::bin_t    rd_addr,
	output hist_pkg::count_t  rd_data
);

	hist_pkg::count_t mem [`HIST_NUM_BINS];  // storage array, no reset
	hist_pkg::count_t dout;                  // registered read word

	// write port
	always_ff @(posedge clk_a) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read port, read-first on a collision
	always_ff @(posedge clk_a) begin
		if (rd_en)
			dout <= mem[rd_addr];
	end

	assign rd_data = dout;

	// addresses must be clean whenever their port is enabled
	a_wr_addr_known: assert property (
		@(posedge clk_a) wr_en |-> !$isunknown(wr_addr)
	) else $error("dp_sram write address unknown");

	a_rd_addr_known: assert property (
		@(posedge clk_a) rd_en |-> !$isunknown(rd_addr)
	) else $error("dp_sram read address unknown");

endmodule

// ==== hist_pkg.sv ====
/*
 * Shared types for the histogram engine.
 * Widths come from the size header. Refer to the names by scope,
 * for example hist_pkg::bin_t.
 */
`include "hist_params.svh"

package hist_pkg;

	typedef logic [`HIST_BIN_BITS-1:0]   bin_t;    // bin index
	typedef logic [`HIST_COUNT_BITS-1:0] count_t;  // one bank's count
	typedef logic [`HIST_COUNT_BITS:0]   total_t;  // sum of two banks, no overflow

	typedef struct packed {
		logic valid;  // one-cycle sample strobe
		bin_t bin;
	} lane_t;

	typedef struct packed {
		logic   valid;  // bank answered a host read
		count_t count;
	} bank_result_t;

	typedef struct packed {
		logic   valid;
		total_t total;  // both lanes added
	} read_result_t;

	typedef enum logic {BANK_IDLE, BANK_CLEAR} bank_state_t;

endpackage

// ==== hist_params.svh ====
/*
 * Size macros for the two-lane histogram engine.
 * Include this header in every RTL file and in the package.
 * The bin index width sets the number of bins and the length of the clear sweep.
 * The count width is one bank's counter width. The merged total is one bit wider.
 */
`ifndef HIST_PARAMS_SVH
`define HIST_PARAMS_SVH

// bin index width, 64 bins
`define HIST_BIN_BITS 6

// one bank's counter width, wraps at the top
`define HIST_COUNT_BITS 18

`define HIST_NUM_BINS (1 << `HIST_BIN_BITS)  // bins per bank and clear sweep length

`endif
